//--- sources.f
+incdir+include
hw/wbPkg.sv
hw/memWbReg.sv
hw/wbStage.sv
hw/regFile.sv
hw/wbTop.sv
tb/tbClock.sv
tb/wbTb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= wbTb
RTL_TOP   ?= wbTop
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- tb/wbTb.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wbTb
    import wbPkg::*;
();

    localparam int NUM_RANDOM = 200;
    localparam int OP_COUNT = NUM_RANDOM + 50;
    localparam int WATCHDOG_CYCLES = OP_COUNT * 10 + 100;

    typedef struct packed {
        word_t     aluOut;
        word_t     hi;
        word_t     lo;
        word_t     pc;
        wbSel_t    wbSel;
        regAddr_t  dst;
        loadType_t loadType;
        word_t     dmOut;
        word_t     outB;
        regsWr_t   regsWr;
        excCode_t  excCode;
        logic      inDelaySlot;
    } entry_t;

    typedef struct packed {
        logic     gprWe;
        regAddr_t gprAddr;
        word_t    gprData;
        logic     hiWe;
        word_t    hiData;
        logic     loWe;
        word_t    loData;
        logic     excValid;
        excCode_t excCode;
        word_t    epc;
    } effect_t;

    logic     clk;
    logic     rst;
    logic     memWbWr;
    logic     wbFlush;
    entry_t   inEntry;
    string    inName;
    regAddr_t rsAddr;
    regAddr_t rtAddr;
    word_t    rsData;
    word_t    rtData;
    word_t    hiOut;
    word_t    loOut;
    logic     excValid;
    excCode_t excCode;
    word_t    excEpc;

    // Mirror of the MEM/WB register and the architectural state.
    entry_t      modelEntry;
    string       modelName;
    word_t       shadow [`REG_N];
    word_t       shadowHi;
    word_t       shadowLo;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] rngState = 32'hfd99;
    regAddr_t    prevDst1 = '0;
    regAddr_t    prevDst2 = '0;

    tbClock i_clock (
        .clk (clk),
        .rst (rst)
    );

    wbTop i_dut (
        .clk            (clk),
        .rst            (rst),
        .memWbWr        (memWbWr),
        .wbFlush        (wbFlush),
        .memAluOut      (inEntry.aluOut),
        .memHi          (inEntry.hi),
        .memLo          (inEntry.lo),
        .memPc          (inEntry.pc),
        .memWbSel       (inEntry.wbSel),
        .memDst         (inEntry.dst),
        .memLoadType    (inEntry.loadType),
        .memDmOut       (inEntry.dmOut),
        .memOutB        (inEntry.outB),
        .memRegsWr      (inEntry.regsWr),
        .memExcCode     (inEntry.excCode),
        .memInDelaySlot (inEntry.inDelaySlot),
        .rsAddr         (rsAddr),
        .rtAddr         (rtAddr),
        .rsData         (rsData),
        .rtData         (rtData),
        .hiOut          (hiOut),
        .loOut          (loOut),
        .excValid       (excValid),
        .excCode        (excCode),
        .excEpc         (excEpc)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] nextRand();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Expected writeback effect of one register entry.
    function automatic effect_t refEffect(input entry_t e);
        effect_t r;
        word_t   lane;
        word_t   loadVal;
        logic    exc;
        lane = e.dmOut >> {e.aluOut[1:0], 3'b000};
        case (e.loadType[1:0])
            `LT_BYTE: loadVal = {{24{e.loadType[2] & lane[7]}}, lane[7:0]};
            `LT_HALF: loadVal = {{16{e.loadType[2] & lane[15]}}, lane[15:0]};
            default:  loadVal = e.dmOut;
        endcase
        case (e.wbSel)
            `WBSEL_ALU:  r.gprData = e.aluOut;
            `WBSEL_LOAD: r.gprData = loadVal;
            `WBSEL_LINK: r.gprData = e.pc + 32'd8;
            default:     r.gprData = e.outB;
        endcase
        exc = (e.excCode != `EXC_NONE);
        r.gprWe = e.regsWr[2] & ~exc;
        r.hiWe = e.regsWr[1] & ~exc;
        r.loWe = e.regsWr[0] & ~exc;
        r.gprAddr = e.dst;
        r.hiData = e.hi;
        r.loData = e.lo;
        r.excValid = exc;
        r.excCode = e.excCode;
        r.epc = e.inDelaySlot ? e.pc - 32'd4 : e.pc;
        return r;
    endfunction

    // Reads follow the two most recent entries, one pending and one committed.
    task automatic applyEntry(input entry_t e, input logic wr, input logic fl, input string name);
        @(posedge clk);
        #1;
        inEntry = e;
        memWbWr = wr;
        wbFlush = fl;
        inName = name;
        rsAddr = prevDst1;
        rtAddr = prevDst2;
        prevDst2 = prevDst1;
        prevDst1 = e.dst;
    endtask

    task automatic randomEntry(output entry_t e, output logic wr, output logic fl);
        logic [31:0] r;
        e.aluOut = nextRand();
        e.hi = nextRand();
        e.lo = nextRand();
        e.dmOut = nextRand();
        e.outB = nextRand();
        r = nextRand();
        e.pc = {r[31:2], 2'b00};
        r = nextRand();
        e.wbSel = r[1:0];
        e.dst = r[6:2];
        e.loadType = {r[7], 2'(r[15:8] % 8'd3)};
        if (e.loadType[1:0] == `LT_HALF) begin
            e.aluOut[0] = 1'b0;
        end
        e.regsWr = r[18:16];
        e.excCode = (r[21:19] == 3'd0) ? r[26:22] : `EXC_NONE;
        e.inDelaySlot = r[27];
        wr = (r[30:28] != 3'd0);
        r = nextRand();
        fl = (r[3:0] == 4'd0);
    endtask

    // Model update at each edge, comparison in the middle of the cycle.
    initial begin
        effect_t r;
        word_t   expRs;
        word_t   expRt;
        word_t   expHi;
        word_t   expLo;
        forever begin
            @(posedge clk);
            if (!rst) begin
                modelEntry = '0;
                modelName = "reset";
                for (int i = 0; i < `REG_N; i++) begin
                    shadow[i] = '0;
                end
                shadowHi = '0;
                shadowLo = '0;
            end else begin
                r = refEffect(modelEntry);
                if (r.gprWe && r.gprAddr != '0) begin
                    shadow[r.gprAddr] = r.gprData;
                end
                if (r.hiWe) begin
                    shadowHi = r.hiData;
                end
                if (r.loWe) begin
                    shadowLo = r.loData;
                end
                if (wbFlush) begin
                    modelEntry = '0;
                    modelName = inName;
                end else if (memWbWr) begin
                    modelEntry = inEntry;
                    modelName = inName;
                end
            end
            @(negedge clk);
            if (rst) begin
                checks++;
                r = refEffect(modelEntry);
                expRs = (rsAddr == '0) ? '0 :
                        (r.gprWe && r.gprAddr == rsAddr) ? r.gprData : shadow[rsAddr];
                expRt = (rtAddr == '0) ? '0 :
                        (r.gprWe && r.gprAddr == rtAddr) ? r.gprData : shadow[rtAddr];
                expHi = r.hiWe ? r.hiData : shadowHi;
                expLo = r.loWe ? r.loData : shadowLo;
                if (excValid !== r.excValid) begin
                    $display("Fail %s excValid expected %b actual %b",
                             modelName, r.excValid, excValid);
                    errors++;
                end
                if (r.excValid && excCode !== r.excCode) begin
                    $display("Fail %s excCode expected %h actual %h",
                             modelName, r.excCode, excCode);
                    errors++;
                end
                if (r.excValid && excEpc !== r.epc) begin
                    $display("Fail %s excEpc expected %h actual %h", modelName, r.epc, excEpc);
                    errors++;
                end
                if (rsData !== expRs) begin
                    $display("Fail %s rsData[%0d] expected %h actual %h",
                             modelName, rsAddr, expRs, rsData);
                    errors++;
                end
                if (rtData !== expRt) begin
                    $display("Fail %s rtData[%0d] expected %h actual %h",
                             modelName, rtAddr, expRt, rtData);
                    errors++;
                end
                if (hiOut !== expHi) begin
                    $display("Fail %s hiOut expected %h actual %h", modelName, expHi, hiOut);
                    errors++;
                end
                if (loOut !== expLo) begin
                    $display("Fail %s loOut expected %h actual %h", modelName, expLo, loOut);
                    errors++;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before the stimulus finished");
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        entry_t e;
        logic   wr;
        logic   fl;
        word_t  dmPat [2];
        inEntry = '0;
        inName = "idle";
        memWbWr = 1'b0;
        wbFlush = 1'b0;
        rsAddr = '0;
        rtAddr = '0;
        // Lanes alternate sign so both extensions show up.
        dmPat[0] = 32'h8a7f_c135;
        dmPat[1] = 32'h7f01_40ff;
        @(posedge rst);

        // Plain writebacks, including one to register 0.
        e = '0;
        e.regsWr = 3'b100;
        e.wbSel = `WBSEL_ALU;
        e.dst = 5'd5;
        e.aluOut = 32'h1234_5678;
        applyEntry(e, 1'b1, 1'b0, "alu");
        e.wbSel = `WBSEL_LINK;
        e.dst = 5'd31;
        e.pc = 32'h0040_0100;
        applyEntry(e, 1'b1, 1'b0, "link");
        e.wbSel = `WBSEL_MOVE;
        e.dst = 5'd9;
        e.outB = 32'hcafe_f00d;
        applyEntry(e, 1'b1, 1'b0, "move");
        e.wbSel = `WBSEL_ALU;
        e.dst = 5'd0;
        e.aluOut = 32'hffff_ffff;
        applyEntry(e, 1'b1, 1'b0, "zeroReg");

        // Loads at every legal offset, signed and unsigned.
        for (int d = 0; d < 2; d++) begin
            for (int s = 0; s < 2; s++) begin
                for (int o = 0; o < 4; o++) begin
                    e = '0;
                    e.wbSel = `WBSEL_LOAD;
                    e.regsWr = 3'b100;
                    e.dmOut = dmPat[d];
                    e.aluOut = 32'h1000_0000 | 32'(o);
                    e.dst = regAddr_t'(8 + o);
                    e.loadType = {s[0], `LT_BYTE};
                    applyEntry(e, 1'b1, 1'b0, "loadByte");
                    if (o % 2 == 0) begin
                        e.dst = regAddr_t'(16 + o);
                        e.loadType = {s[0], `LT_HALF};
                        applyEntry(e, 1'b1, 1'b0, "loadHalf");
                    end
                end
                e.aluOut = 32'h1000_0000;
                e.dst = 5'd20;
                e.loadType = {s[0], `LT_WORD};
                applyEntry(e, 1'b1, 1'b0, "loadWord");
            end
        end

        // HI and LO flags one at a time, then together.
        e = '0;
        e.hi = 32'h0bad_0001;
        e.lo = 32'h0bad_0002;
        e.regsWr = 3'b010;
        applyEntry(e, 1'b1, 1'b0, "hiOnly");
        e.hi = 32'h0bad_0003;
        e.lo = 32'h0bad_0004;
        e.regsWr = 3'b001;
        applyEntry(e, 1'b1, 1'b0, "loOnly");
        e.hi = 32'h0bad_0005;
        e.lo = 32'h0bad_0006;
        e.regsWr = 3'b011;
        applyEntry(e, 1'b1, 1'b0, "hiLo");

        // Exceptions outside and inside a delay slot.
        e = '0;
        e.regsWr = 3'b111;
        e.dst = 5'd5;
        e.aluOut = 32'hdead_beef;
        e.hi = 32'h1111_1111;
        e.lo = 32'h2222_2222;
        e.pc = 32'h0040_0200;
        e.excCode = 5'd12;
        applyEntry(e, 1'b1, 1'b0, "exc");
        e.pc = 32'h0040_0204;
        e.excCode = 5'd4;
        e.inDelaySlot = 1'b1;
        applyEntry(e, 1'b1, 1'b0, "excSlot");

        // Stall holds the entry, flush discards the next one.
        e = '0;
        e.regsWr = 3'b100;
        e.dst = 5'd6;
        e.aluOut = 32'h0600_0006;
        applyEntry(e, 1'b1, 1'b0, "stall");
        e.dst = 5'd7;
        e.excCode = 5'd10;
        applyEntry(e, 1'b0, 1'b0, "stall");
        applyEntry(e, 1'b0, 1'b0, "stall");
        e.excCode = `EXC_NONE;
        e.dst = 5'd10;
        applyEntry(e, 1'b1, 1'b1, "flush");
        e.excCode = 5'd8;
        applyEntry(e, 1'b1, 1'b1, "flush");
        applyEntry('0, 1'b1, 1'b0, "bubble");

        for (int n = 0; n < NUM_RANDOM; n++) begin
            randomEntry(e, wr, fl);
            applyEntry(e, wr, fl, "random");
        end
        repeat (3) applyEntry('0, 1'b1, 1'b0, "drain");
        @(negedge clk);
        @(negedge clk);
        #1;
        $display("Errors: %0d, cycles checked: %0d", errors, checks);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- tb/tbClock.sv
`timescale 1ns/10ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset is released just after the second rising edge.
    initial begin
        rst = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst = 1'b1;
    end

endmodule

//--- hw/wbTop.sv
`timescale 1ns/10ps

module wbTop
    import wbPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      memWbWr,
    input  logic      wbFlush,

    input  word_t     memAluOut,
    input  word_t     memHi,
    input  word_t     memLo,
    input  word_t     memPc,
    input  wbSel_t    memWbSel,
    input  regAddr_t  memDst,
    input  loadType_t memLoadType,
    input  word_t     memDmOut,
    input  word_t     memOutB,
    input  regsWr_t   memRegsWr,
    input  excCode_t  memExcCode,
    input  logic      memInDelaySlot,

    input  regAddr_t  rsAddr,
    input  regAddr_t  rtAddr,
    output word_t     rsData,
    output word_t     rtData,
    output word_t     hiOut,
    output word_t     loOut,

    output logic      excValid,
    output excCode_t  excCode,
    output word_t     excEpc
);

    word_t     wbAluOut;
    word_t     wbHi;
    word_t     wbLo;
    word_t     wbPc;
    wbSel_t    wbWbSel;
    regAddr_t  wbDst;
    loadType_t wbLoadType;
    word_t     wbDmOut;
    word_t     wbOutB;
    regsWr_t   wbRegsWr;
    excCode_t  wbExcCode;
    logic      wbInDelaySlot;

    logic      rfWe;
    regAddr_t  rfAddr;
    word_t     rfData;
    logic      hiWe;
    word_t     hiData;
    logic      loWe;
    word_t     loData;

    memWbReg u_memWbReg (
        .clk            (clk),
        .rst            (rst),
        .wbFlush        (wbFlush),
        .memWbWr        (memWbWr),
        .memAluOut      (memAluOut),
        .memHi          (memHi),
        .memLo          (memLo),
        .memPc          (memPc),
        .memWbSel       (memWbSel),
        .memDst         (memDst),
        .memLoadType    (memLoadType),
        .memDmOut       (memDmOut),
        .memOutB        (memOutB),
        .memRegsWr      (memRegsWr),
        .memExcCode     (memExcCode),
        .memInDelaySlot (memInDelaySlot),
        .wbAluOut       (wbAluOut),
        .wbHi           (wbHi),
        .wbLo           (wbLo),
        .wbPc           (wbPc),
        .wbWbSel        (wbWbSel),
        .wbDst          (wbDst),
        .wbLoadType     (wbLoadType),
        .wbDmOut        (wbDmOut),
        .wbOutB         (wbOutB),
        .wbRegsWr       (wbRegsWr),
        .wbExcCode      (wbExcCode),
        .wbInDelaySlot  (wbInDelaySlot)
    );

    wbStage u_wbStage (
        .clk           (clk),
        .rst           (rst),
        .wbAluOut      (wbAluOut),
        .wbHi          (wbHi),
        .wbLo          (wbLo),
        .wbPc          (wbPc),
        .wbWbSel       (wbWbSel),
        .wbDst         (wbDst),
        .wbLoadType    (wbLoadType),
        .wbDmOut       (wbDmOut),
        .wbOutB        (wbOutB),
        .wbRegsWr      (wbRegsWr),
        .wbExcCode     (wbExcCode),
        .wbInDelaySlot (wbInDelaySlot),
        .rfWe          (rfWe),
        .rfAddr        (rfAddr),
        .rfData        (rfData),
        .hiWe          (hiWe),
        .hiData        (hiData),
        .loWe          (loWe),
        .loData        (loData),
        .excValid      (excValid),
        .excCode       (excCode),
        .excEpc        (excEpc)
    );

    regFile u_regFile (
        .clk    (clk),
        .rst    (rst),
        .rfWe   (rfWe),
        .rfAddr (rfAddr),
        .rfData (rfData),
        .hiWe   (hiWe),
        .hiData (hiData),
        .loWe   (loWe),
        .loData (loData),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rsData),
        .rtData (rtData),
        .hiOut  (hiOut),
        .loOut  (loOut)
    );

endmodule

//--- hw/regFile.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module regFile
    import wbPkg::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     rfWe,
    input  regAddr_t rfAddr,
    input  word_t    rfData,
    input  logic     hiWe,
    input  word_t    hiData,
    input  logic     loWe,
    input  word_t    loData,

    input  regAddr_t rsAddr,
    input  regAddr_t rtAddr,
    output word_t    rsData,
    output word_t    rtData,
    output word_t    hiOut,
    output word_t    loOut
);

    word_t regs [`REG_N];
    word_t hiReg;
    word_t loReg;

    // Entry 0 is never written, so it stays at its reset value.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < `REG_N; i++) begin
                regs[i] <= '0;
            end
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (rfWe && rfAddr != '0) begin
                regs[rfAddr] <= rfData;
            end
            if (hiWe) begin
                hiReg <= hiData;
            end
            if (loWe) begin
                loReg <= loData;
            end
        end
    end

    // Reads forward the write that commits at the coming edge.
    assign rsData = (rfWe && rfAddr != '0 && rfAddr == rsAddr) ? rfData : regs[rsAddr];
    assign rtData = (rfWe && rfAddr != '0 && rfAddr == rtAddr) ? rfData : regs[rtAddr];
    assign hiOut  = hiWe ? hiData : hiReg;
    assign loOut  = loWe ? loData : loReg;

    aZeroReg: assert property (@(posedge clk) disable iff (!rst)
        (rsAddr == '0) |-> (rsData == '0));

endmodule

//--- hw/wbStage.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module wbStage
    import wbPkg::*;
(
    input  logic      clk,
    input  logic      rst,

    input  word_t     wbAluOut,
    input  word_t     wbHi,
    input  word_t     wbLo,
    input  word_t     wbPc,
    input  wbSel_t    wbWbSel,
    input  regAddr_t  wbDst,
    input  loadType_t wbLoadType,
    input  word_t     wbDmOut,
    input  word_t     wbOutB,
    input  regsWr_t   wbRegsWr,
    input  excCode_t  wbExcCode,
    input  logic      wbInDelaySlot,

    output logic      rfWe,
    output regAddr_t  rfAddr,
    output word_t     rfData,
    output logic      hiWe,
    output word_t     hiData,
    output logic      loWe,
    output word_t     loData,
    output logic      excValid,
    output excCode_t  excCode,
    output word_t     excEpc
);

    logic [7:0]  loadByte;
    logic [15:0] loadHalf;
    logic        loadSigned;
    word_t       loadData;

    assign loadSigned = wbLoadType[`LT_SIGN_BIT];

    // Byte lanes are picked by the low address bits (little endian).
    always_comb begin
        case (wbAluOut[1:0])
            2'd0:    loadByte = wbDmOut[7:0];
            2'd1:    loadByte = wbDmOut[15:8];
            2'd2:    loadByte = wbDmOut[23:16];
            default: loadByte = wbDmOut[31:24];
        endcase
        loadHalf = wbAluOut[1] ? wbDmOut[31:16] : wbDmOut[15:0];
    end

    always_comb begin
        case (wbLoadType[1:0])
            `LT_BYTE: loadData = {{(`DATA_W-8){loadSigned & loadByte[7]}}, loadByte};
            `LT_HALF: loadData = {{(`DATA_W-16){loadSigned & loadHalf[15]}}, loadHalf};
            default:  loadData = wbDmOut;
        endcase
    end

    // Value for the general register file.
    always_comb begin
        case (wbWbSel)
            `WBSEL_ALU:  rfData = wbAluOut;
            `WBSEL_LOAD: rfData = loadData;
            // Return address skips the delay slot.
            `WBSEL_LINK: rfData = wbPc + 32'd8;
            default:     rfData = wbOutB;
        endcase
    end

    assign excValid = (wbExcCode != `EXC_NONE);
    assign excCode  = wbExcCode;
    // Restart at the branch when the faulting instruction sits in its slot.
    assign excEpc   = wbInDelaySlot ? wbPc - 32'd4 : wbPc;

    // An excepting instruction must not change architectural state.
    assign rfWe   = wbRegsWr[`RW_GPR] & ~excValid;
    assign hiWe   = wbRegsWr[`RW_HI] & ~excValid;
    assign loWe   = wbRegsWr[`RW_LO] & ~excValid;
    assign rfAddr = wbDst;
    assign hiData = wbHi;
    assign loData = wbLo;

    // Halfword loads arrive at even offsets.
    aHalfAligned: assert property (@(posedge clk) disable iff (!rst)
        (rfWe && wbWbSel == `WBSEL_LOAD && wbLoadType[1:0] == `LT_HALF) |-> !wbAluOut[0]);

endmodule

//--- hw/memWbReg.sv
`timescale 1ns/10ps
`include "wb_defs.svh"

module memWbReg
    import wbPkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wbFlush,
    input  logic      memWbWr,

    input  word_t     memAluOut,
    input  word_t     memHi,
    input  word_t     memLo,
    input  word_t     memPc,
    input  wbSel_t    memWbSel,
    input  regAddr_t  memDst,
    input  loadType_t memLoadType,
    input  word_t     memDmOut,
    input  word_t     memOutB,
    input  regsWr_t   memRegsWr,
    input  excCode_t  memExcCode,
    input  logic      memInDelaySlot,

    output word_t     wbAluOut,
    output word_t     wbHi,
    output word_t     wbLo,
    output word_t     wbPc,
    output wbSel_t    wbWbSel,
    output regAddr_t  wbDst,
    output loadType_t wbLoadType,
    output word_t     wbDmOut,
    output word_t     wbOutB,
    output regsWr_t   wbRegsWr,
    output excCode_t  wbExcCode,
    output logic      wbInDelaySlot
);

    // Flush takes priority over the write enable.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst || wbFlush) begin
            wbAluOut      <= '0;
            wbHi          <= '0;
            wbLo          <= '0;
            wbPc          <= '0;
            wbWbSel       <= '0;
            wbDst         <= '0;
            wbLoadType    <= '0;
            wbDmOut       <= '0;
            wbOutB        <= '0;
            wbRegsWr      <= '0;
            wbExcCode     <= `EXC_NONE;
            wbInDelaySlot <= 1'b0;
        end else if (memWbWr) begin
            wbAluOut      <= memAluOut;
            wbHi          <= memHi;
            wbLo          <= memLo;
            wbPc          <= memPc;
            wbWbSel       <= memWbSel;
            wbDst         <= memDst;
            wbLoadType    <= memLoadType;
            wbDmOut       <= memDmOut;
            wbOutB        <= memOutB;
            wbRegsWr      <= memRegsWr;
            wbExcCode     <= memExcCode;
            wbInDelaySlot <= memInDelaySlot;
        end
    end

    // A flushed slot must carry no write and no exception into writeback.
    aFlushClears: assert property (@(posedge clk) disable iff (!rst)
        wbFlush |=> (wbRegsWr == '0 && wbExcCode == `EXC_NONE && wbPc == '0
                     && wbAluOut == '0 && !wbInDelaySlot));

endmodule

//--- hw/wbPkg.sv
`include "wb_defs.svh"

package wbPkg;

    // Data or address word.
    typedef logic [`DATA_W-1:0] word_t;

    // General register index.
    typedef logic [$clog2(`REG_N)-1:0] regAddr_t;

    // Writeback source select, see the WBSEL codes.
    typedef logic [1:0] wbSel_t;

    // Load type.
    // Bit 2 is the sign flag, bits 1:0 the access size.
    typedef logic [2:0] loadType_t;

    // Write type.
    // Bit 2 writes the general register, bit 1 HI, bit 0 LO.
    typedef logic [2:0] regsWr_t;

    // Exception code, zero when the entry is clean.
    typedef logic [4:0] excCode_t;

endpackage

//--- include/wb_defs.svh
`ifndef WB_DEFS_SVH
`define WB_DEFS_SVH

// Machine word and register file size.
`define DATA_W 32
`define REG_N 32

// Writeback select codes.
`define WBSEL_ALU 2'd0
`define WBSEL_LOAD 2'd1
`define WBSEL_LINK 2'd2
`define WBSEL_MOVE 2'd3

// Exception code for a clean entry.
`define EXC_NONE 5'd0

// Load size codes, held in bits 1:0 of the load type.
`define LT_BYTE 2'd0
`define LT_HALF 2'd1
`define LT_WORD 2'd2
// Load type bit 2 set means sign extension.
`define LT_SIGN_BIT 2

// Bit positions inside the write type.
`define RW_GPR 2
`define RW_HI 1
`define RW_LO 0

`endif
